/* project.f */
rtl/stage_pkg.sv
rtl/stage_if.sv
rtl/key_extract.sv
rtl/lookup_engine.sv
rtl/action_engine.sv
rtl/last_stage.sv
verification/tb_last_stage.sv

/* rtl/action_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module action_engine import stage_pkg::*; (
    input  logic axis_clk,
    input  logic aresetn,

    act_if.dst   in,

    output phv_t phv_out,
    output logic phv_out_valid,
    input  logic phv_out_ready
);

    phv_t  phv_next;
    cont_t imm_ext;
    cont_t src_val;
    logic  accept;

    assign imm_ext = {{(CONT_W - 16){1'b0}}, in.act.imm};
    assign src_val = in.phv.cont[in.act.src];

    // single ALU on the destination container
    always_comb begin
        phv_next = in.phv;
        case (in.act.op)
            ACT_SET: begin
                phv_next.cont[in.act.dst] = imm_ext;
            end
            ACT_ADD: begin
                phv_next.cont[in.act.dst] = src_val + imm_ext;
            end
            ACT_SUB: begin
                phv_next.cont[in.act.dst] = src_val - imm_ext;
            end
            ACT_NOP: begin
                phv_next = in.phv;
            end
            default: begin
                phv_next = in.phv;
            end
        endcase
        // queue selection comes from the action
        phv_next.queue_mask = in.act.queue_mask;
    end

    assign in.ready = !phv_out_valid || phv_out_ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            phv_out_valid <= 1'b0;
        end else if (accept) begin
            phv_out_valid <= 1'b1;
        end else if (phv_out_ready) begin
            phv_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            phv_out <= phv_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/key_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module key_extract import stage_pkg::*; (
    input  logic                  axis_clk,
    input  logic                  aresetn,

    input  logic                  cfg_valid,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_data,

    input  phv_t                  phv_in,
    input  logic                  phv_in_valid,
    output logic                  stage_ready,

    key_if.src                    out
);

    logic [CONT_IDX_W-1:0] sel_hi;
    logic [CONT_IDX_W-1:0] sel_lo;
    logic [KEY_W-1:0]      key_mask;
    logic [KEY_W-1:0]      key_next;
    logic                  accept;

    // key select and mask registers
    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            sel_hi   <= '0;
            sel_lo   <= '0;
            key_mask <= '0;
        end else if (cfg_valid) begin
            if (cfg_addr == CFG_KEY_SEL) begin
                sel_hi <= cfg_data[CONT_IDX_W-1:0];
                sel_lo <= cfg_data[2*CONT_IDX_W-1:CONT_IDX_W];
            end
            if (cfg_addr == CFG_KEY_MASK) begin
                key_mask <= cfg_data[KEY_W-1:0];
            end
        end
    end

    assign key_next = {phv_in.cont[sel_hi], phv_in.cont[sel_lo]} & key_mask;

    // take a new PHV when the output slot is free or draining
    assign stage_ready = !out.valid || out.ready;
    assign accept      = phv_in_valid && stage_ready;

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            out.phv <= phv_in;
            out.key <= key_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/last_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module last_stage import stage_pkg::*; #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                  axis_clk,
    input  logic                  aresetn,

    input  logic                  cfg_valid,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_data,

    input  phv_t                  phv_in,
    input  logic                  phv_in_valid,
    output logic                  stage_ready_out,

    output phv_t                  phv_out_0,
    output logic                  phv_out_valid_0,
    input  logic                  phv_fifo_ready_0,

    output phv_t                  phv_out_1,
    output logic                  phv_out_valid_1,
    input  logic                  phv_fifo_ready_1,

    output phv_t                  phv_out_2,
    output logic                  phv_out_valid_2,
    input  logic                  phv_fifo_ready_2,

    output phv_t                  phv_out_3,
    output logic                  phv_out_valid_3,
    input  logic                  phv_fifo_ready_3
);

    phv_t                  ae_phv;
    logic                  ae_valid;
    logic                  ae_ready;
    logic [NUM_QUEUES-1:0] fifo_ready;
    logic [NUM_QUEUES-1:0] q_valid;

    key_if k_if ();
    act_if a_if ();

    key_extract i_key_extract (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .cfg_valid    (cfg_valid),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .phv_in       (phv_in),
        .phv_in_valid (phv_in_valid),
        .stage_ready  (stage_ready_out),
        .out          (k_if.src)
    );

    lookup_engine #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) i_lookup_engine (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .in        (k_if.dst),
        .out       (a_if.src)
    );

    action_engine i_action_engine (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .in            (a_if.dst),
        .phv_out       (ae_phv),
        .phv_out_valid (ae_valid),
        .phv_out_ready (ae_ready)
    );

    assign fifo_ready = {phv_fifo_ready_3, phv_fifo_ready_2,
                         phv_fifo_ready_1, phv_fifo_ready_0};

    // all selected queues must take it together; zero mask just drains
    assign ae_ready = &(fifo_ready | ~ae_phv.queue_mask);
    assign q_valid  = {NUM_QUEUES{ae_valid}} & ae_phv.queue_mask;

    assign phv_out_valid_0 = q_valid[0];
    assign phv_out_valid_1 = q_valid[1];
    assign phv_out_valid_2 = q_valid[2];
    assign phv_out_valid_3 = q_valid[3];

    assign phv_out_0 = ae_phv;
    assign phv_out_1 = ae_phv;
    assign phv_out_2 = ae_phv;
    assign phv_out_3 = ae_phv;

endmodule

`default_nettype wire

/* rtl/lookup_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module lookup_engine import stage_pkg::*; #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                  axis_clk,
    input  logic                  aresetn,

    input  logic                  cfg_valid,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_data,

    key_if.dst                    in,
    act_if.src                    out
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    logic [KEY_W-1:0]       match_key [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] match_vld;
    act_t                   act_mem [TABLE_DEPTH];

    logic [CFG_ADDR_W-1:0]  match_off;
    logic [CFG_ADDR_W-1:0]  act_off;
    logic                   match_wr;
    logic                   act_wr;

    logic                   hit;
    logic [IDX_W-1:0]       hit_idx;
    logic                   advance;

    // step one registers
    logic                   s1_valid;
    logic                   s1_hit;
    logic [IDX_W-1:0]       s1_idx;
    phv_t                   s1_phv;

    assign match_off = cfg_addr - CFG_MATCH_BASE;
    assign act_off   = cfg_addr - CFG_ACT_BASE;
    assign match_wr  = cfg_valid && (int'(match_off) < TABLE_DEPTH);
    assign act_wr    = cfg_valid && (int'(act_off) < TABLE_DEPTH);

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            match_vld <= '0;
        end else if (match_wr) begin
            match_vld[match_off[IDX_W-1:0]] <= cfg_data[KEY_W-1];
        end
    end

    // top key bit is the valid flag and is stored as zero
    always_ff @(posedge axis_clk) begin
        if (match_wr) begin
            match_key[match_off[IDX_W-1:0]] <= {1'b0, cfg_data[KEY_W-2:0]};
        end
        if (act_wr) begin
            act_mem[act_off[IDX_W-1:0]] <= act_t'(cfg_data[$bits(act_t)-1:0]);
        end
    end

    // parallel compare, lowest index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (match_vld[i] && (match_key[i] == in.key)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    // both steps move on one ready
    assign advance  = !out.valid || out.ready;
    assign in.ready = advance;

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            s1_valid  <= 1'b0;
            out.valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in.valid;
            out.valid <= s1_valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (advance) begin
            s1_hit  <= hit;
            s1_idx  <= hit_idx;
            s1_phv  <= in.phv;
            out.phv <= s1_phv;
            out.act <= s1_hit ? act_mem[s1_idx] : DEFAULT_ACT;
        end
    end

endmodule

`default_nettype wire

/* rtl/stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// key_extract -> lookup_engine
interface key_if import stage_pkg::*; ();
    logic             valid;
    logic             ready;
    phv_t             phv;
    logic [KEY_W-1:0] key;

    modport src (output valid, output phv, output key, input ready);
    modport dst (input valid, input phv, input key, output ready);
endinterface

// lookup_engine -> action_engine
interface act_if import stage_pkg::*; ();
    logic valid;
    logic ready;
    phv_t phv;
    act_t act;

    modport src (output valid, output phv, output act, input ready);
    modport dst (input valid, input phv, input act, output ready);
endinterface

`default_nettype wire

/* rtl/stage_pkg.sv */
`default_nettype none

package stage_pkg;

    localparam int NUM_CONT   = 8;
    localparam int CONT_W     = 32;
    localparam int CONT_IDX_W = $clog2(NUM_CONT);
    localparam int NUM_QUEUES = 4;
    localparam int KEY_W      = 2 * CONT_W;
    localparam int CFG_ADDR_W = 8;
    localparam int CFG_DATA_W = 64;

    typedef logic [CONT_W-1:0] cont_t;

    // container 7 sits at the top and the queue mask in the low bits
    typedef struct packed {
        cont_t [NUM_CONT-1:0]  cont;
        logic [NUM_QUEUES-1:0] queue_mask;
    } phv_t;

    typedef enum logic [1:0] {
        ACT_NOP = 2'd0,
        ACT_SET = 2'd1,
        ACT_ADD = 2'd2,
        ACT_SUB = 2'd3
    } act_op_e;

    typedef struct packed {
        act_op_e               op;
        logic [CONT_IDX_W-1:0] dst;
        logic [CONT_IDX_W-1:0] src;
        logic [15:0]           imm;
        logic [NUM_QUEUES-1:0] queue_mask;
    } act_t;

    // configuration map
    localparam logic [CFG_ADDR_W-1:0] CFG_KEY_SEL    = 8'h00;
    localparam logic [CFG_ADDR_W-1:0] CFG_KEY_MASK   = 8'h01;
    localparam logic [CFG_ADDR_W-1:0] CFG_MATCH_BASE = 8'h10;
    localparam logic [CFG_ADDR_W-1:0] CFG_ACT_BASE   = 8'h20;

    // on a miss leave the PHV alone and send it to queue 0
    localparam act_t DEFAULT_ACT = '{
        op:         ACT_NOP,
        dst:        '0,
        src:        '0,
        imm:        '0,
        queue_mask: 4'b0001
    };

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the last_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_last_stage -f project.f

# the log decides the result
./obj_dir/Vtb_last_stage | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* verification/tb_last_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_last_stage import stage_pkg::*; ();

    localparam int TABLE_DEPTH = 16;
    localparam int TIMEOUT     = 1000;
    localparam logic [7:0] HI_KEYS [8] = '{8'h11, 8'h33, 8'h55, 8'h77,
                                           8'h99, 8'hBB, 8'hDD, 8'h12};
    localparam logic [7:0] LO_KEYS [8] = '{8'h22, 8'h44, 8'h66, 8'h88,
                                           8'hAA, 8'hCC, 8'hEE, 8'h34};

    logic                  axis_clk = 1'b0;
    logic                  aresetn;
    logic                  cfg_valid;
    logic [7:0]            cfg_addr;
    logic [63:0]           cfg_data;
    phv_t                  phv_in;
    logic                  phv_in_valid;
    logic                  stage_ready_out;
    phv_t                  out_phv [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] out_valid;
    logic [NUM_QUEUES-1:0] fifo_ready;
    logic                  rand_ready;
    logic [31:0]           lcg_state = 32'd43107;

    // configuration model
    logic [2:0]             m_sel_hi;
    logic [2:0]             m_sel_lo;
    logic [63:0]            m_key_mask;
    logic [63:0]            m_key [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] m_vld;
    act_t                   m_act [TABLE_DEPTH];

    phv_t sb [NUM_QUEUES][$];

    always #2 axis_clk = ~axis_clk;

    last_stage #(.TABLE_DEPTH(TABLE_DEPTH)) i_last_stage (
        .axis_clk         (axis_clk),
        .aresetn          (aresetn),
        .cfg_valid        (cfg_valid),
        .cfg_addr         (cfg_addr),
        .cfg_data         (cfg_data),
        .phv_in           (phv_in),
        .phv_in_valid     (phv_in_valid),
        .stage_ready_out  (stage_ready_out),
        .phv_out_0        (out_phv[0]),
        .phv_out_valid_0  (out_valid[0]),
        .phv_fifo_ready_0 (fifo_ready[0]),
        .phv_out_1        (out_phv[1]),
        .phv_out_valid_1  (out_valid[1]),
        .phv_fifo_ready_1 (fifo_ready[1]),
        .phv_out_2        (out_phv[2]),
        .phv_out_valid_2  (out_valid[2]),
        .phv_fifo_ready_2 (fifo_ready[2]),
        .phv_out_3        (out_phv[3]),
        .phv_out_valid_3  (out_valid[3]),
        .phv_fifo_ready_3 (fifo_ready[3])
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic phv_t random_phv();
        phv_t        p;
        logic [31:0] r;
        for (int i = 0; i < NUM_CONT; i++) p.cont[i] = lcg_next();
        r = lcg_next();
        p.queue_mask = r[31:28];
        return p;
    endfunction

    // key bytes land in containers 1 and 2
    function automatic phv_t keyed_phv(input logic [7:0] hi, input logic [7:0] lo);
        phv_t p;
        p = random_phv();
        p.cont[1][7:0] = hi;
        p.cont[2][7:0] = lo;
        return p;
    endfunction

    function automatic act_t make_act(input act_op_e op, input logic [2:0] dst,
                                      input logic [2:0] src, input logic [15:0] imm,
                                      input logic [3:0] mask);
        act_t a;
        a.op         = op;
        a.dst        = dst;
        a.src        = src;
        a.imm        = imm;
        a.queue_mask = mask;
        return a;
    endfunction

    function automatic phv_t expect_phv(input phv_t p);
        logic [63:0] key;
        act_t        a;
        phv_t        r;
        logic        found;
        key   = {p.cont[m_sel_hi], p.cont[m_sel_lo]} & m_key_mask;
        a     = DEFAULT_ACT;
        found = 1'b0;
        for (int k = 0; k < TABLE_DEPTH; k++) begin
            if (!found && m_vld[k] && m_key[k] == key) begin
                a     = m_act[k];
                found = 1'b1;
            end
        end
        r = p;
        case (a.op)
            ACT_SET: r.cont[a.dst] = {16'h0, a.imm};
            ACT_ADD: r.cont[a.dst] = p.cont[a.src] + {16'h0, a.imm};
            ACT_SUB: r.cont[a.dst] = p.cont[a.src] - {16'h0, a.imm};
            default: r = p;
        endcase
        r.queue_mask = a.queue_mask;
        return r;
    endfunction

    function automatic int sb_total();
        int n;
        n = 0;
        for (int q = 0; q < NUM_QUEUES; q++) n += sb[q].size();
        return n;
    endfunction

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic write_cfg(input logic [7:0] addr, input logic [63:0] data);
        int idx;
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge axis_clk);
        cfg_valid = 1'b0;
        if (addr == CFG_KEY_SEL) begin
            m_sel_hi = data[2:0];
            m_sel_lo = data[5:3];
        end else if (addr == CFG_KEY_MASK) begin
            m_key_mask = data;
        end else if (addr >= CFG_MATCH_BASE && addr < CFG_MATCH_BASE + 8'(TABLE_DEPTH)) begin
            idx        = int'(addr - CFG_MATCH_BASE);
            m_key[idx] = {1'b0, data[62:0]};
            m_vld[idx] = data[63];
        end else if (addr >= CFG_ACT_BASE && addr < CFG_ACT_BASE + 8'(TABLE_DEPTH)) begin
            idx        = int'(addr - CFG_ACT_BASE);
            m_act[idx] = act_t'(data[27:0]);
        end
    endtask

    task automatic set_entry(input int idx, input logic vld, input logic [63:0] key,
                             input act_t act);
        write_cfg(CFG_MATCH_BASE + 8'(idx), {vld, key[62:0]});
        write_cfg(CFG_ACT_BASE + 8'(idx), {36'h0, act});
    endtask

    task automatic send_phv(input phv_t p);
        phv_t e;
        int   waited;
        phv_in       = p;
        phv_in_valid = 1'b1;
        waited       = 0;
        #1;
        while (!stage_ready_out && waited < TIMEOUT) begin
            @(negedge axis_clk);
            #1;
            waited++;
        end
        if (!stage_ready_out) begin
            $display("timeout waiting for stage_ready_out");
            stop_with_failure();
        end
        // taken on the coming rising edge
        e = expect_phv(p);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (e.queue_mask[q]) sb[q].push_back(e);
        end
        @(negedge axis_clk);
        phv_in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (sb_total() != 0 && waited < TIMEOUT) begin
            @(negedge axis_clk);
            waited++;
        end
        if (sb_total() != 0) begin
            $display("timeout waiting for the expected PHVs to come out");
            stop_with_failure();
        end
        rand_ready = 1'b0;
        // dropped PHVs leave no trace, so let the four-cycle pipe empty
        repeat (4) @(negedge axis_clk);
    endtask

    always @(negedge axis_clk) begin
        logic [31:0] r;
        if (rand_ready) begin
            r          = lcg_next();
            fifo_ready = r[27:24] | r[31:28];
        end else begin
            fifo_ready = '1;
        end
    end

    // a multi-queue PHV moves only when every selected queue is ready
    always @(posedge axis_clk) begin
        phv_t want;
        if (aresetn && out_valid != '0 && (out_valid & ~fifo_ready) == '0) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (out_valid[q]) begin
                    assert (sb[q].size() != 0) else begin
                        $display("queue %0d delivered a PHV that was not expected", q);
                        stop_with_failure();
                    end
                    want = sb[q].pop_front();
                    assert (out_phv[q] == want) else begin
                        $display("[ERROR] phv_out_%0d expected %h got %h", q, want, out_phv[q]);
                        stop_with_failure();
                    end
                end
            end
        end
    end

    initial begin
        phv_t        p;
        logic [31:0] r;
        aresetn      = 1'b0;
        cfg_valid    = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        phv_in       = '0;
        phv_in_valid = 1'b0;
        fifo_ready   = '1;
        rand_ready   = 1'b0;
        m_sel_hi     = '0;
        m_sel_lo     = '0;
        m_key_mask   = '0;
        m_vld        = '0;
        for (int k = 0; k < TABLE_DEPTH; k++) m_act[k] = DEFAULT_ACT;
        repeat (8) @(posedge axis_clk);
        @(negedge axis_clk);
        aresetn = 1'b1;
        #1;
        assert (out_valid == '0) else begin
            $display("[ERROR] phv_out_valid expected 0 got %h", out_valid);
            stop_with_failure();
        end
        assert (stage_ready_out == 1'b1) else begin
            $display("[ERROR] stage_ready_out expected 1 got %h", stage_ready_out);
            stop_with_failure();
        end
        @(negedge axis_clk);

        // empty table, every PHV misses
        for (int i = 0; i < 20; i++) send_phv(random_phv());
        wait_drain();

        write_cfg(CFG_KEY_SEL, 64'h11);
        write_cfg(CFG_KEY_MASK, 64'h0000_00FF_0000_00FF);
        set_entry(0, 1'b1, 64'h0000_0011_0000_0022,
                  make_act(ACT_SET, 3'd3, 3'd0, 16'hBEEF, 4'b0010));
        set_entry(1, 1'b1, 64'h0000_0033_0000_0044,
                  make_act(ACT_ADD, 3'd4, 3'd5, 16'h0100, 4'b0100));
        set_entry(2, 1'b1, 64'h0000_0055_0000_0066,
                  make_act(ACT_SUB, 3'd6, 3'd7, 16'hFFFF, 4'b1011));
        set_entry(3, 1'b1, 64'h0000_0077_0000_0088,
                  make_act(ACT_ADD, 3'd0, 3'd1, 16'h8000, 4'b1000));
        set_entry(5, 1'b1, 64'h0000_0099_0000_00AA,
                  make_act(ACT_SET, 3'd7, 3'd0, 16'h0005, 4'b0001));
        set_entry(9, 1'b1, 64'h0000_0099_0000_00AA,
                  make_act(ACT_SET, 3'd7, 3'd0, 16'h0009, 4'b1111));
        set_entry(6, 1'b1, 64'h0000_00BB_0000_00CC,
                  make_act(ACT_SET, 3'd0, 3'd0, 16'h0001, 4'b0000));
        set_entry(7, 1'b0, 64'h0000_00DD_0000_00EE,
                  make_act(ACT_SET, 3'd0, 3'd0, 16'h0007, 4'b1111));

        send_phv(keyed_phv(8'h11, 8'h22));
        send_phv(keyed_phv(8'h33, 8'h44));
        p = keyed_phv(8'h55, 8'h66);
        p.cont[7] = 32'h0000_0005;
        send_phv(p);
        p = keyed_phv(8'h77, 8'h88);
        p.cont[1] = 32'hFFFF_FF77;
        send_phv(p);
        send_phv(keyed_phv(8'h99, 8'hAA));
        send_phv(keyed_phv(8'hBB, 8'hCC));
        send_phv(keyed_phv(8'hDD, 8'hEE));
        wait_drain();

        rand_ready = 1'b1;
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            if (r[31:30] == 2'b00) p = random_phv();
            else p = keyed_phv(HI_KEYS[r[29:27]], LO_KEYS[r[29:27]]);
            send_phv(p);
        end
        wait_drain();

        // new key from the low half of container 5
        write_cfg(CFG_KEY_SEL, 64'h05);
        write_cfg(CFG_KEY_MASK, 64'h0000_FFFF_0000_0000);
        set_entry(10, 1'b1, 64'h0000_1234_0000_0000,
                  make_act(ACT_SUB, 3'd2, 3'd3, 16'h5A5A, 4'b0110));
        rand_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            p = random_phv();
            r = lcg_next();
            if (r[31]) p.cont[5][15:0] = 16'h1234;
            send_phv(p);
        end
        send_phv(keyed_phv(8'h11, 8'h22));
        wait_drain();

        if (sb_total() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("expected PHVs are left over at the end of the run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
